//--- hw/retire_queue_pkg.sv
//////////////////////////////////////////////////
// retire queue shared widths, depth and types
// entry layout and FIFO storage style selection
//////////////////////////////////////////////////

package retire_queue_pkg;

    //////////////////////////////////////////////////
    // widths
    localparam int DATA_W   = 32;
    localparam int REG_ID_W = 5;
    // tag wraps every 8 issues
    localparam int SEQ_W    = 3;
    localparam int COUNT_W  = 16;

    // tag, rd, data packed in one word
    localparam int ENTRY_W  = SEQ_W + REG_ID_W + DATA_W;

    //////////////////////////////////////////////////
    // queue depth, must stay a power of two
    localparam int FIFO_DEPTH = 4;
    // ram / shift chain index
    localparam int FIFO_IDX_W = $clog2(FIFO_DEPTH);
    // occupancy count 0..FIFO_DEPTH
    localparam int OCC_W      = $clog2(FIFO_DEPTH + 1);

    //////////////////////////////////////////////////
    // payload types
    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [REG_ID_W-1:0] reg_id_t;
    typedef logic [SEQ_W-1:0]    seq_t;
    typedef logic [COUNT_W-1:0]  count_t;

    // {seq, rd, data}, tag in the top bits
    typedef logic [ENTRY_W-1:0]  entry_t;

    // storage styles of the result buffer
    typedef enum logic [1:0] {
        LUTRAM_FIFO,
        NON_MUXED_INPUT_FIFO,
        NON_MUXED_OUTPUT_FIFO
    } fifo_style_t;

    // shift-in chain by default
    localparam fifo_style_t FIFO_STYLE = NON_MUXED_INPUT_FIFO;

endpackage

//--- hw/one_hot_occupancy.sv
//////////////////////////////////////////////////
// one-hot occupancy tracker for the result FIFO
//////////////////////////////////////////////////

`timescale 1ns/1ps

module one_hot_occupancy (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  logic pop,
    output logic early_full,
    output logic full,
    output logic empty,
    output logic valid,
    output logic early_valid,
    output logic two_plus
);
    import retire_queue_pkg::*;

    // bit k set means k entries held
    logic [FIFO_DEPTH:0] occ;
    logic [FIFO_DEPTH:0] occ_next;

    //////////////////////////////////////////////////
    // next occupancy
    always_comb begin
        occ_next = occ;
        // push with pop leaves the count alone
        if (push && !pop) begin
            occ_next = {occ[FIFO_DEPTH-1:0], 1'b0};
        end else if (pop && !push) begin
            occ_next = {1'b0, occ[FIFO_DEPTH:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // start empty, bit 0 hot
            occ <= {{FIFO_DEPTH{1'b0}}, 1'b1};
        end else begin
            occ <= occ_next;
        end
    end

    //////////////////////////////////////////////////
    // status flags straight from the one-hot bits
    assign full     = occ[FIFO_DEPTH];
    assign empty    = occ[0];
    assign valid    = ~occ[0];
    // neither 0 nor 1 entries held
    assign two_plus = ~occ[0] & ~occ[1];

    // previews of next cycle
    assign early_full  = occ_next[FIFO_DEPTH];
    assign early_valid = ~occ_next[0];

endmodule

//--- hw/result_fifo.sv
//////////////////////////////////////////////////
// small result FIFO, three storage styles
// not overflow or underflow safe
//////////////////////////////////////////////////

`timescale 1ns/1ps

module result_fifo #(
    parameter retire_queue_pkg::fifo_style_t FIFO_TYPE = retire_queue_pkg::FIFO_STYLE
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     push,
    input  logic                     pop,
    input  retire_queue_pkg::entry_t data_in,
    output retire_queue_pkg::entry_t data_out,
    output logic                     valid,
    output logic                     full
);
    import retire_queue_pkg::*;

    logic two_plus;

    //////////////////////////////////////////////////
    // occupancy flags
    one_hot_occupancy u_occupancy (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .pop        (pop),
        .early_full (),
        .full       (full),
        .empty      (),
        .valid      (valid),
        .early_valid(),
        .two_plus   (two_plus)
    );

    //////////////////////////////////////////////////
    // storage
    if (FIFO_TYPE == LUTRAM_FIFO) begin : g_lutram
        entry_t                ram [FIFO_DEPTH];
        logic [FIFO_IDX_W-1:0] rd_idx;
        logic [FIFO_IDX_W-1:0] wr_idx;

        // indices wrap since depth is a power of two
        always_ff @(posedge clk) begin
            if (rst) begin
                rd_idx <= '0;
                wr_idx <= '0;
            end else begin
                if (pop) begin
                    rd_idx <= rd_idx + 1'b1;
                end
                if (push) begin
                    wr_idx <= wr_idx + 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (push) begin
                ram[wr_idx] <= data_in;
            end
        end

        assign data_out = ram[rd_idx];

    end else if (FIFO_TYPE == NON_MUXED_INPUT_FIFO) begin : g_shift_in
        entry_t                chain [FIFO_DEPTH];
        logic [FIFO_IDX_W-1:0] rd_idx;

        // read point tracks the oldest entry in the chain
        always_ff @(posedge clk) begin
            if (rst) begin
                rd_idx <= '0;
            end else if (push && valid && !pop) begin
                rd_idx <= rd_idx + 1'b1;
            end else if (pop && two_plus && !push) begin
                rd_idx <= rd_idx - 1'b1;
            end
        end

        // new data enters at slot 0, rest move up
        always_ff @(posedge clk) begin
            if (push) begin
                chain[0] <= data_in;
                for (int i = 1; i < FIFO_DEPTH; i++) begin
                    chain[i] <= chain[i-1];
                end
            end
        end

        assign data_out = chain[rd_idx];

    end else begin : g_fixed_out
        entry_t           slot     [FIFO_DEPTH];
        // extra top slot for push and pop while full
        entry_t           slot_new [FIFO_DEPTH+1];
        logic [OCC_W-1:0] wr_cnt;

        always_ff @(posedge clk) begin
            if (rst) begin
                wr_cnt <= '0;
            end else if (push && !pop) begin
                wr_cnt <= wr_cnt + 1'b1;
            end else if (pop && !push) begin
                wr_cnt <= wr_cnt - 1'b1;
            end
        end

        // write lands at the occupancy index
        always_comb begin
            for (int i = 0; i < FIFO_DEPTH; i++) begin
                slot_new[i] = (push && wr_cnt == OCC_W'(i)) ? data_in : slot[i];
            end
            slot_new[FIFO_DEPTH] = data_in;
        end

        // pop shifts everything toward slot 0
        always_ff @(posedge clk) begin
            for (int i = 0; i < FIFO_DEPTH; i++) begin
                slot[i] <= pop ? slot_new[i+1] : slot_new[i];
            end
        end

        assign data_out = slot[0];
    end

endmodule

//--- hw/issue_tagger.sv
//////////////////////////////////////////////////
// issue side, tags results and pushes entries
//////////////////////////////////////////////////

`timescale 1ns/1ps

module issue_tagger (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue,
    input  retire_queue_pkg::reg_id_t issue_rd,
    input  retire_queue_pkg::data_t   issue_data,
    input  logic                      full,
    output logic                      push,
    output retire_queue_pkg::entry_t  data_in
);
    import retire_queue_pkg::*;

    // tag of the next accepted issue
    seq_t seq;

    // issue while full is dropped
    assign push = issue & ~full;

    // tag on top, then rd, then data
    assign data_in = {seq, issue_rd, issue_data};

    //////////////////////////////////////////////////
    // sequence counter
    always_ff @(posedge clk) begin
        if (rst) begin
            seq <= '0;
        end else if (push) begin
            // wraps 7 -> 0
            seq <= seq + 1'b1;
        end
    end

endmodule

//--- hw/retire_unit.sv
//////////////////////////////////////////////////
// retire side, pops entries into registered
// retire outputs and counts retirements
//////////////////////////////////////////////////

`timescale 1ns/1ps

module retire_unit (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      valid,
    input  retire_queue_pkg::entry_t  data_out,
    input  logic                      retire_ready,
    output logic                      pop,
    output logic                      retire_valid,
    output retire_queue_pkg::reg_id_t retire_rd,
    output retire_queue_pkg::data_t   retire_data,
    output retire_queue_pkg::seq_t    retire_seq,
    output logic                      rf_we,
    output retire_queue_pkg::count_t  retired_count
);
    import retire_queue_pkg::*;

    seq_t    entry_seq;
    reg_id_t entry_rd;
    data_t   entry_data;

    // unpack head entry
    assign {entry_seq, entry_rd, entry_data} = data_out;

    // take the head whenever allowed
    assign pop = valid & retire_ready;

    //////////////////////////////////////////////////
    // control and counter
    always_ff @(posedge clk) begin
        if (rst) begin
            retire_valid  <= 1'b0;
            rf_we         <= 1'b0;
            retired_count <= '0;
        end else begin
            retire_valid <= pop;
            // x0 never written
            rf_we        <= pop && (entry_rd != '0);
            if (pop) begin
                retired_count <= retired_count + 1'b1;
            end
        end
    end

    // payload, loaded on pop only
    always_ff @(posedge clk) begin
        if (pop) begin
            retire_rd   <= entry_rd;
            retire_data <= entry_data;
            retire_seq  <= entry_seq;
        end
    end

endmodule

//--- hw/retire_queue_top.sv
//////////////////////////////////////////////////
// retire queue top, tagger -> FIFO -> retire
//////////////////////////////////////////////////

`timescale 1ns/1ps

module retire_queue_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      issue,
    input  retire_queue_pkg::reg_id_t issue_rd,
    input  retire_queue_pkg::data_t   issue_data,
    input  logic                      retire_ready,
    output logic                      issue_stall,
    output logic                      retire_valid,
    output retire_queue_pkg::reg_id_t retire_rd,
    output retire_queue_pkg::data_t   retire_data,
    output retire_queue_pkg::seq_t    retire_seq,
    output logic                      rf_we,
    output retire_queue_pkg::count_t  retired_count
);
    import retire_queue_pkg::*;

    // issue -> fifo
    logic   push;
    logic   full;
    entry_t data_in;

    // fifo -> retire
    logic   pop;
    logic   valid;
    entry_t data_out;

    // stall is just the queue full flag
    assign issue_stall = full;

    //////////////////////////////////////////////////
    // stages
    issue_tagger u_tagger (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .issue_rd  (issue_rd),
        .issue_data(issue_data),
        .full      (full),
        .push      (push),
        .data_in   (data_in)
    );

    result_fifo #(
        .FIFO_TYPE(FIFO_STYLE)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .push    (push),
        .pop     (pop),
        .data_in (data_in),
        .data_out(data_out),
        .valid   (valid),
        .full    (full)
    );

    retire_unit u_retire (
        .clk          (clk),
        .rst          (rst),
        .valid        (valid),
        .data_out     (data_out),
        .retire_ready (retire_ready),
        .pop          (pop),
        .retire_valid (retire_valid),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data),
        .retire_seq   (retire_seq),
        .rf_we        (rf_we),
        .retired_count(retired_count)
    );

endmodule

//--- tests/retire_queue_checker.sv
//////////////////////////////////////////////////
// concurrent checks on the retire queue protocol
//////////////////////////////////////////////////

`timescale 1ns/1ps

module retire_queue_checker (
    input logic                      clk,
    input logic                      rst,
    input logic                      push,
    input logic                      full,
    input logic                      pop,
    input logic                      valid,
    input logic                      issue_stall,
    input logic                      retire_valid,
    input logic                      rf_we,
    input retire_queue_pkg::reg_id_t retire_rd
);

    // failures seen so far, read by the testbench at the end
    int fail_count = 0;

    //////////////////////////////////////////////////
    // FIFO handshake
    a_push_not_full: assert property (@(posedge clk) disable iff (rst) push |-> !full)
        else begin $error("push while queue full"); fail_count++; end

    a_pop_valid: assert property (@(posedge clk) disable iff (rst) pop |-> valid)
        else begin $error("pop with no valid entry"); fail_count++; end

    //////////////////////////////////////////////////
    // retire side
    // retire_valid is pop delayed by one cycle, both ways
    a_pop_retire: assert property (@(posedge clk) disable iff (rst) pop |=> retire_valid)
        else begin $error("pop not followed by retire_valid"); fail_count++; end

    a_idle_retire: assert property (@(posedge clk) disable iff (rst) !pop |=> !retire_valid)
        else begin $error("retire_valid without a pop"); fail_count++; end

    a_rf_we: assert property (@(posedge clk) disable iff (rst)
        rf_we |-> (retire_valid && retire_rd != '0))
        else begin $error("rf_we without a valid nonzero rd"); fail_count++; end

    // first cycle out of reset
    a_after_reset: assert property (@(posedge clk) $fell(rst) |-> (!issue_stall && !retire_valid))
        else begin $error("stall or retire_valid high after reset"); fail_count++; end

endmodule

//--- tests/tb_retire_queue.sv
//////////////////////////////////////////////////
// retire queue testbench with stimulus and scoreboard
//////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_retire_queue;
    import retire_queue_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int STALL_TIMEOUT = 20;
    localparam int DRAIN_TIMEOUT = 60;

    logic    clk;
    logic    rst;
    logic    issue;
    logic    retire_ready;
    logic    issue_stall;
    logic    retire_valid;
    logic    rf_we;
    reg_id_t issue_rd;
    reg_id_t retire_rd;
    data_t   issue_data;
    data_t   retire_data;
    seq_t    retire_seq;
    seq_t    exp_seq;
    count_t  retired_count;

    int seed = 32'h9349_bd03;
    int mismatch_count = 0;
    int other_errors = 0;
    int accepted_total = 0;
    int retire_total = 0;
    int phase_start;
    int waited;
    string test_name = "reset";
    entry_t exp_q[$];
    entry_t head;

    retire_queue_top u_dut (.*);

    bind retire_queue_top retire_queue_checker u_checker (
        .clk(clk), .rst(rst), .push(push), .full(full), .pop(pop), .valid(valid),
        .issue_stall(issue_stall), .retire_valid(retire_valid), .rf_we(rf_we),
        .retire_rd(retire_rd)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_field(input string field, input logic [31:0] expv, input logic [31:0] got);
        assert (expv == got) else begin
            $display("mismatch %s %s: expected %0h actual %0h", test_name, field, expv, got);
            mismatch_count++;
        end
    endtask

    // new inputs 2 ns after the edge
    task automatic drive_cycle(input logic iss, input reg_id_t rd, input logic rdy);
        @(posedge clk);
        #2;
        issue        = iss;
        issue_rd     = rd;
        issue_data   = $random(seed);
        retire_ready = rdy;
    endtask

    // retire with issue off until every accepted entry is back
    task automatic drain_queue;
        waited = 0;
        do begin
            drive_cycle(1'b0, '0, 1'b1);
            waited++;
        end while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT);
        if (exp_q.size() != 0) begin
            $display("timeout in %s: queue did not drain", test_name);
            other_errors++;
        end
    endtask

    //////////////////////////////////////////////////
    // scoreboard samples inputs and outputs at the edge
    always @(posedge clk) begin
        if (!rst) begin
            if (retire_valid) begin
                if (exp_q.size() == 0) begin
                    $display("retirement in %s with no issue pending", test_name);
                    other_errors++;
                end else begin
                    head = exp_q.pop_front();
                    retire_total++;
                    check_field("seq", head[39:37], retire_seq);
                    check_field("rd", head[36:32], retire_rd);
                    check_field("data", head[31:0], retire_data);
                    check_field("rf_we", head[36:32] != '0, rf_we);
                    check_field("count", retire_total, retired_count);
                end
            end
            // accepted only while not stalled
            if (issue && !issue_stall) begin
                exp_q.push_back({exp_seq, issue_rd, issue_data});
                // wraps by width
                exp_seq = exp_seq + 1'b1;
                accepted_total++;
            end
        end
    end

    initial begin
        {rst, issue, retire_ready, issue_rd, issue_data, exp_seq} = '0;
        rst = 1'b1;
        repeat (8) @(posedge clk);
        #2 rst = 1'b0;

        test_name = "single_issue";
        drive_cycle(1'b1, $random(seed), 1'b1);
        drain_queue();

        // fill with retire held off
        test_name = "fill_stall";
        phase_start = accepted_total;
        waited = 0;
        while (!issue_stall && waited < STALL_TIMEOUT) begin
            drive_cycle(1'b1, $random(seed), 1'b0);
            waited++;
        end
        if (!issue_stall) begin
            $display("timeout in %s: issue_stall never rose", test_name);
            other_errors++;
        end
        check_field("accepted", FIFO_DEPTH, accepted_total - phase_start);
        // this one must be dropped
        drive_cycle(1'b1, $random(seed), 1'b0);
        drain_queue();

        test_name = "in_order_wrap";
        repeat (20) drive_cycle(1'b1, $random(seed), 1'b1);
        drain_queue();

        // x0 on even steps
        test_name = "x0_write_enable";
        for (int i = 0; i < 8; i++) begin
            drive_cycle(1'b1, (i % 2 == 0) ? reg_id_t'(0) : reg_id_t'(i), 1'b1);
        end
        drain_queue();

        test_name = "random_traffic";
        repeat (200) drive_cycle($random(seed), $random(seed), $random(seed));
        drain_queue();
        check_field("final_count", accepted_total, retired_count);

        $display("errors: mismatches %0d, other %0d, assertion failures %0d",
                 mismatch_count, other_errors, u_dut.u_checker.fail_count);
        if (mismatch_count + other_errors + u_dut.u_checker.fail_count == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

//--- project.f
hw/retire_queue_pkg.sv
hw/one_hot_occupancy.sv
hw/result_fifo.sv
hw/issue_tagger.sv
hw/retire_unit.sv
hw/retire_queue_top.sv
tests/retire_queue_checker.sv
tests/tb_retire_queue.sv

//--- Bender.yml
package:
  name: retire_queue

sources:
  - hw/retire_queue_pkg.sv
  - hw/one_hot_occupancy.sv
  - hw/result_fifo.sv
  - hw/issue_tagger.sv
  - hw/retire_unit.sv
  - hw/retire_queue_top.sv
  - target: test
    files:
      - tests/retire_queue_checker.sv
      - tests/tb_retire_queue.sv
